// File: build.f
+incdir+verif
source/corePkg.sv
source/pipeFifo.sv
source/issueStage.sv
source/execStage.sv
source/coreTop.sv
verif/coreTb.sv

// File: source/corePkg.sv
`default_nettype none

package corePkg;

	// ========================================================================
	// basic data types
	// ========================================================================

	// one data word
	typedef logic [31:0] word;
	// architectural register number
	typedef logic [4:0] regAddr;

	// number of architectural registers
	localparam int regCount = 32;

	// ========================================================================
	// instruction encodings
	// ========================================================================

	// primary opcodes, instr[31:26]
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddi    = 6'h08;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opSlti    = 6'h0a;
	localparam logic [5:0] opAndi    = 6'h0c;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opXori    = 6'h0e;
	localparam logic [5:0] opLui     = 6'h0f;

	// funct codes of the special group, instr[5:0]
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnNor  = 6'h27;
	localparam logic [5:0] fnSlt  = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	// ========================================================================
	// pipeline packets
	// ========================================================================

	// operation performed by the execute stage
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
	} aluOp;

	// retirement status of one instruction
	typedef enum logic [1:0] {
		statusOk       = 2'd0,
		statusOverflow = 2'd1,
		statusReserved = 2'd2
	} resStatus;

	// issue stage to execute stage
	typedef struct packed {
		aluOp       op;
		word        a;
		// rt value or extended immediate
		word        b;
		logic [4:0] shamt;
		regAddr     dest;
		logic       checkOverflow;
		logic       reserved;
	} issuePkt;

	// execute stage to retirement
	typedef struct packed {
		regAddr   dest;
		word      data;
		resStatus status;
	} resultPkt;

endpackage

`default_nettype wire

// File: source/coreTop.sv
`timescale 1ns/1ps
`default_nettype none

module coreTop #(
	parameter int issueDepth = 4,
	parameter int retireDepth = 2
) (
	input wire clk,
	input wire arstN,
	// instruction input
	input wire instrValid,
	output logic instrReady,
	input wire corePkg::word instr,
	// retired results
	output logic resValid,
	input wire resReady,
	output corePkg::regAddr resReg,
	output corePkg::word resData,
	output corePkg::resStatus resStatus
);

	// issue stage to issue fifo
	logic issueValid;
	logic issueReady;
	corePkg::issuePkt issuePkt;

	// issue fifo to execute stage
	logic execValid;
	logic execReady;
	corePkg::issuePkt execPkt;

	// execute stage to retire fifo
	logic doneValid;
	logic doneReady;
	corePkg::resultPkt donePkt;

	// retire fifo head, also fed back for writeback
	corePkg::resultPkt resultPkt;

	// ========================================================================
	// pipeline
	// ========================================================================

	issueStage issue (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.instr(instr),
		.issueValid(issueValid),
		.issueReady(issueReady),
		.issuePkt(issuePkt),
		.retireFire({resValid, resReady}),
		.retirePkt(resultPkt)
	);

	pipeFifo #(
		.payloadT(corePkg::issuePkt),
		.depth(issueDepth)
	) issueFifo (
		.clk(clk),
		.arstN(arstN),
		.inValid(issueValid),
		.inReady(issueReady),
		.inData(issuePkt),
		.outValid(execValid),
		.outReady(execReady),
		.outData(execPkt)
	);

	execStage exec (
		.clk(clk),
		.arstN(arstN),
		.execValid(execValid),
		.execReady(execReady),
		.issuePkt(execPkt),
		.doneValid(doneValid),
		.doneReady(doneReady),
		.resultPkt(donePkt)
	);

	pipeFifo #(
		.payloadT(corePkg::resultPkt),
		.depth(retireDepth)
	) retireFifo (
		.clk(clk),
		.arstN(arstN),
		.inValid(doneValid),
		.inReady(doneReady),
		.inData(donePkt),
		.outValid(resValid),
		.outReady(resReady),
		.outData(resultPkt)
	);

	// result fields to plain ports
	assign resReg    = resultPkt.dest;
	assign resData   = resultPkt.data;
	assign resStatus = resultPkt.status;

endmodule

`default_nettype wire

// File: source/execStage.sv
`timescale 1ns/1ps
`default_nettype none

module execStage (
	input wire clk,
	input wire arstN,
	// from the issue fifo
	input wire execValid,
	output logic execReady,
	input wire corePkg::issuePkt issuePkt,
	// towards the retire fifo
	output logic doneValid,
	input wire doneReady,
	output corePkg::resultPkt resultPkt
);

	corePkg::word a;
	corePkg::word b;
	corePkg::word sum;
	corePkg::word diff;
	corePkg::word aluRes;
	logic [4:0] shamt;
	logic overflow;
	corePkg::resultPkt nextPkt;
	logic take;

	// ========================================================================
	// ALU
	// ========================================================================

	assign a     = issuePkt.a;
	assign b     = issuePkt.b;
	assign shamt = issuePkt.shamt;
	assign sum   = a + b;
	assign diff  = a - b;

	always_comb begin
		overflow = 1'b0;
		case (issuePkt.op)
			corePkg::aluAdd: begin
				aluRes   = sum;
				// same input signs, different result sign
				overflow = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			corePkg::aluSub: begin
				aluRes   = diff;
				// differing input signs, result sign flips away from a
				overflow = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			corePkg::aluAnd:  aluRes = a & b;
			corePkg::aluOr:   aluRes = a | b;
			corePkg::aluXor:  aluRes = a ^ b;
			corePkg::aluNor:  aluRes = ~(a | b);
			corePkg::aluSlt:  aluRes = {31'b0, $signed(a) < $signed(b)};
			corePkg::aluSltu: aluRes = {31'b0, a < b};
			// shifts act on the rt operand
			corePkg::aluSll:  aluRes = b << shamt;
			corePkg::aluSrl:  aluRes = b >> shamt;
			corePkg::aluSra:  aluRes = $signed(b) >>> shamt;
			corePkg::aluLui:  aluRes = {b[15:0], 16'h0000};
			default:          aluRes = '0;
		endcase
	end

	// ========================================================================
	// result packet
	// ========================================================================

	always_comb begin
		nextPkt.dest = issuePkt.dest;
		nextPkt.data = aluRes;
		if (issuePkt.reserved) begin
			// nothing meaningful was computed
			nextPkt.data   = '0;
			nextPkt.status = corePkg::statusReserved;
		end else if (issuePkt.checkOverflow && overflow) begin
			// wrapped value still reported
			nextPkt.status = corePkg::statusOverflow;
		end else begin
			nextPkt.status = corePkg::statusOk;
		end
	end

	// ========================================================================
	// output register
	// ========================================================================

	// free slot, or the held result leaves this cycle
	assign execReady = ~doneValid | doneReady;
	assign take      = execValid & execReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			doneValid <= 1'b0;
		end else if (take) begin
			doneValid <= 1'b1;
		end else if (doneReady) begin
			doneValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			resultPkt <= nextPkt;
		end
	end

endmodule

`default_nettype wire

// File: source/issueStage.sv
`timescale 1ns/1ps
`default_nettype none

module issueStage (
	input wire clk,
	input wire arstN,
	// instruction input handshake
	input wire instrValid,
	output logic instrReady,
	input wire corePkg::word instr,
	// towards the issue fifo
	output logic issueValid,
	input wire issueReady,
	output corePkg::issuePkt issuePkt,
	// retirement feedback, {resValid, resReady}
	input wire [1:0] retireFire,
	input wire corePkg::resultPkt retirePkt
);

	// instruction fields
	logic [5:0] opcode;
	logic [5:0] funct;
	corePkg::regAddr rs;
	corePkg::regAddr rt;
	corePkg::regAddr rd;
	logic [4:0] shamt;
	logic [15:0] imm;

	// decode controls
	corePkg::aluOp op;
	logic isRType;
	logic useRs;
	logic useRt;
	logic signExt;
	logic checkOvf;
	logic reserved;
	logic writesReg;
	corePkg::regAddr dest;
	corePkg::word immExt;

	// register file and scoreboard
	corePkg::word regs [corePkg::regCount];
	corePkg::word rsData;
	corePkg::word rtData;
	logic [corePkg::regCount-1:0] pending;
	logic [corePkg::regCount-1:0] pendingNext;

	// handshake bookkeeping
	logic hazard;
	logic issueFire;
	logic retire;
	logic retireWrite;
	logic retireClear;

	// ========================================================================
	// decode
	// ========================================================================

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign funct  = instr[5:0];
	assign imm    = instr[15:0];

	always_comb begin
		// defaults suit the plain immediate forms
		op       = corePkg::aluAdd;
		isRType  = 1'b0;
		useRs    = 1'b1;
		useRt    = 1'b0;
		signExt  = 1'b1;
		checkOvf = 1'b0;
		reserved = 1'b0;
		case (opcode)
			corePkg::opSpecial: begin
				isRType = 1'b1;
				useRt   = 1'b1;
				case (funct)
					corePkg::fnAdd: begin
						op       = corePkg::aluAdd;
						checkOvf = 1'b1;
					end
					corePkg::fnAddu: op = corePkg::aluAdd;
					corePkg::fnSub: begin
						op       = corePkg::aluSub;
						checkOvf = 1'b1;
					end
					corePkg::fnSubu: op = corePkg::aluSub;
					corePkg::fnAnd:  op = corePkg::aluAnd;
					corePkg::fnOr:   op = corePkg::aluOr;
					corePkg::fnXor:  op = corePkg::aluXor;
					corePkg::fnNor:  op = corePkg::aluNor;
					corePkg::fnSlt:  op = corePkg::aluSlt;
					corePkg::fnSltu: op = corePkg::aluSltu;
					// shifts read rt only, amount from shamt
					corePkg::fnSll: begin
						op    = corePkg::aluSll;
						useRs = 1'b0;
					end
					corePkg::fnSrl: begin
						op    = corePkg::aluSrl;
						useRs = 1'b0;
					end
					corePkg::fnSra: begin
						op    = corePkg::aluSra;
						useRs = 1'b0;
					end
					default: reserved = 1'b1;
				endcase
			end
			corePkg::opAddi: begin
				op       = corePkg::aluAdd;
				checkOvf = 1'b1;
			end
			corePkg::opAddiu: op = corePkg::aluAdd;
			corePkg::opSlti:  op = corePkg::aluSlt;
			// logic immediates are zero extended
			corePkg::opAndi: begin
				op      = corePkg::aluAnd;
				signExt = 1'b0;
			end
			corePkg::opOri: begin
				op      = corePkg::aluOr;
				signExt = 1'b0;
			end
			corePkg::opXori: begin
				op      = corePkg::aluXor;
				signExt = 1'b0;
			end
			corePkg::opLui: begin
				op      = corePkg::aluLui;
				useRs   = 1'b0;
				signExt = 1'b0;
			end
			default: reserved = 1'b1;
		endcase
		// a reserved instruction touches no register
		if (reserved) begin
			useRs = 1'b0;
			useRt = 1'b0;
		end
	end

	// rd for the special group, rt otherwise
	assign dest      = isRType ? rd : rt;
	assign writesReg = ~reserved & (dest != '0);
	assign immExt    = signExt ? {{16{imm[15]}}, imm} : {16'h0000, imm};

	// ========================================================================
	// register file
	// ========================================================================

	// r0 is never written so it reads as zero
	assign rsData = regs[rs];
	assign rtData = regs[rt];

	assign retire      = &retireFire;
	assign retireWrite = retire & (retirePkt.status == corePkg::statusOk)
		& (retirePkt.dest != '0);
	// reserved never set a pending bit, so it must not clear one
	assign retireClear = retire & (retirePkt.status != corePkg::statusReserved);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < corePkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (retireWrite) begin
			regs[retirePkt.dest] <= retirePkt.data;
		end
	end

	// ========================================================================
	// scoreboard and handshake
	// ========================================================================

	// sources for RAW, destination for WAW
	assign hazard = (useRs & pending[rs]) | (useRt & pending[rt])
		| (writesReg & pending[dest]);

	assign instrReady = issueReady & ~hazard;
	assign issueValid = instrValid & ~hazard;
	assign issueFire  = instrValid & instrReady;

	always_comb begin
		pendingNext = pending;
		if (retireClear) begin
			pendingNext[retirePkt.dest] = 1'b0;
		end
		if (issueFire && writesReg) begin
			pendingNext[dest] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pending <= '0;
		end else begin
			pending <= pendingNext;
		end
	end

	// packet to the issue fifo
	always_comb begin
		issuePkt.op            = op;
		issuePkt.a             = rsData;
		issuePkt.b             = isRType ? rtData : immExt;
		issuePkt.shamt         = shamt;
		issuePkt.dest          = dest;
		issuePkt.checkOverflow = checkOvf;
		issuePkt.reserved      = reserved;
	end

endmodule

`default_nettype wire

// File: source/pipeFifo.sv
`timescale 1ns/1ps
`default_nettype none

module pipeFifo #(
	parameter type payloadT = logic,
	parameter int depth = 2
) (
	input wire clk,
	input wire arstN,
	input wire inValid,
	output logic inReady,
	input wire payloadT inData,
	output logic outValid,
	input wire outReady,
	output payloadT outData
);

	localparam int ptrW = $clog2(depth);
	localparam int cntW = $clog2(depth + 1);

	// storage, payload only
	payloadT mem [depth];

	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic [cntW-1:0] countNext;
	// flags kept in flops so both handshake outputs come from registers
	logic full;
	logic notEmpty;
	logic push;
	logic pop;

	// wrap for depths that are not a power of two
	function automatic logic [ptrW-1:0] bump(input logic [ptrW-1:0] p);
		if (p == ptrW'(depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign inReady  = ~full;
	assign outValid = notEmpty;
	// head entry, holds under back-pressure
	assign outData  = mem[rdPtr];

	assign push = inValid & inReady;
	assign pop  = outValid & outReady;

	always_comb begin
		case ({push, pop})
			2'b10:   countNext = count + 1'b1;
			2'b01:   countNext = count - 1'b1;
			default: countNext = count;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			full     <= 1'b0;
			notEmpty <= 1'b0;
		end else begin
			if (push) begin
				wrPtr <= bump(wrPtr);
			end
			if (pop) begin
				rdPtr <= bump(rdPtr);
			end
			count    <= countNext;
			full     <= (countNext == cntW'(depth));
			notEmpty <= (countNext != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
	end

endmodule

`default_nettype wire

// File: verif/coreModel.svh
`ifndef COREMODEL_SVH
`define COREMODEL_SVH

// ===========================================================================
// reference state
// ===========================================================================

logic [31:0] stimSeed = 32'hb43a_7aa8;
// architectural registers as the program order defines them
corePkg::word refRegs [corePkg::regCount] = '{default: '0};
// results still owed by the DUT, oldest first
corePkg::resultPkt expQ [$];

// six bits per entry, used for random picks
localparam logic [77:0] fnTable = {
	corePkg::fnSll, corePkg::fnSrl, corePkg::fnSra, corePkg::fnAdd, corePkg::fnAddu,
	corePkg::fnSub, corePkg::fnSubu, corePkg::fnAnd, corePkg::fnOr, corePkg::fnXor,
	corePkg::fnNor, corePkg::fnSlt, corePkg::fnSltu
};
localparam logic [41:0] opTable = {
	corePkg::opAddi, corePkg::opAddiu, corePkg::opSlti, corePkg::opAndi,
	corePkg::opOri, corePkg::opXori, corePkg::opLui
};

function automatic logic [31:0] lcgStep(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] nextRand();
	stimSeed = lcgStep(stimSeed);
	return stimSeed;
endfunction

// pick in lo..hi, low lcg bits are poor so drop them
function automatic int pickIn(input int lo, input int hi);
	logic [31:0] r;
	r = nextRand() >> 8;
	return lo + int'(r % 32'(hi - lo + 1));
endfunction

function automatic corePkg::word encR(input logic [5:0] fn, input int rd, input int rs,
		input int rt, input int sh);
	return {corePkg::opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic corePkg::word encI(input logic [5:0] op, input int rt, input int rs,
		input logic [15:0] imm);
	return {op, 5'(rs), 5'(rt), imm};
endfunction

// destination and sources drawn from separate ranges
function automatic corePkg::word randomOp(input int dLo, input int dHi, input int sLo,
		input int sHi);
	int kind;
	int d;
	int s1;
	int s2;
	kind = pickIn(0, 19);
	d = pickIn(dLo, dHi);
	s1 = pickIn(sLo, sHi);
	s2 = pickIn(sLo, sHi);
	if (kind < 13) begin
		return encR(fnTable[kind*6 +: 6], d, s1, s2, pickIn(0, 31));
	end
	return encI(opTable[(kind-13)*6 +: 6], d, s1, 16'(nextRand() >> 12));
endfunction

// ===========================================================================
// instruction semantics, applied in acceptance order
// ===========================================================================

function automatic void applyModel(input corePkg::word w);
	corePkg::word a;
	corePkg::word b;
	corePkg::word sImm;
	corePkg::word zImm;
	corePkg::word res;
	longint wide;
	logic ovfChk;
	logic rsv;
	int dst;
	corePkg::resultPkt p;
	a = refRegs[w[25:21]];
	b = refRegs[w[20:16]];
	sImm = {{16{w[15]}}, w[15:0]};
	zImm = {16'h0000, w[15:0]};
	res = '0;
	wide = 0;
	ovfChk = 1'b0;
	rsv = 1'b0;
	dst = (w[31:26] == corePkg::opSpecial) ? int'(w[15:11]) : int'(w[20:16]);
	if (w[31:26] == corePkg::opSpecial) begin
		case (w[5:0])
			corePkg::fnAdd: begin
				wide = longint'($signed(a)) + longint'($signed(b));
				ovfChk = 1'b1;
			end
			corePkg::fnSub: begin
				wide = longint'($signed(a)) - longint'($signed(b));
				ovfChk = 1'b1;
			end
			corePkg::fnAddu: res = a + b;
			corePkg::fnSubu: res = a - b;
			corePkg::fnAnd: res = a & b;
			corePkg::fnOr: res = a | b;
			corePkg::fnXor: res = a ^ b;
			corePkg::fnNor: res = ~(a | b);
			corePkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			corePkg::fnSltu: res = (a < b) ? 32'd1 : 32'd0;
			corePkg::fnSll: res = b << w[10:6];
			corePkg::fnSrl: res = b >> w[10:6];
			corePkg::fnSra: res = $signed(b) >>> w[10:6];
			default: rsv = 1'b1;
		endcase
	end else begin
		case (w[31:26])
			corePkg::opAddi: begin
				wide = longint'($signed(a)) + longint'($signed(sImm));
				ovfChk = 1'b1;
			end
			corePkg::opAddiu: res = a + sImm;
			corePkg::opSlti: res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
			corePkg::opAndi: res = a & zImm;
			corePkg::opOri: res = a | zImm;
			corePkg::opXori: res = a ^ zImm;
			corePkg::opLui: res = {w[15:0], 16'h0000};
			default: rsv = 1'b1;
		endcase
	end
	if (ovfChk) begin
		res = wide[31:0];
	end
	p.dest = 5'(dst);
	p.data = rsv ? '0 : res;
	if (rsv) begin
		p.status = corePkg::statusReserved;
	end else if (ovfChk && (wide != longint'($signed(res)))) begin
		// wrapped value is reported, register untouched
		p.status = corePkg::statusOverflow;
	end else begin
		p.status = corePkg::statusOk;
		if (dst != 0) begin
			refRegs[dst] = res;
		end
	end
	expQ.push_back(p);
endfunction

`endif

// File: verif/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;

	// instructions per test, also sizes the watchdog
	localparam int nSeedOps = 32;
	localparam int nRandom = 40;
	localparam int nChain = 32;
	localparam int nExcept = 14;
	localparam int nPressure = 40;
	localparam int totalInstr = nSeedOps + nRandom + nChain + nExcept + nPressure;
	localparam int limitCycles = 200 * totalInstr + 1000;

	logic clk;
	logic arstN;
	logic instrValid;
	logic instrReady;
	corePkg::word instr;
	logic resValid;
	logic resReady = 1'b0;
	corePkg::regAddr resReg;
	corePkg::word resData;
	corePkg::resStatus resStatus;

	// run counters
	int errors = 0;
	int checked = 0;
	int sent = 0;
	int ovfSeen = 0;
	int rsvSeen = 0;
	// back-pressure generator
	logic throttle = 1'b0;
	logic [31:0] pressSeed = 32'hb43a_7aa8;
	corePkg::resultPkt expPkt;

	`include "coreModel.svh"

	coreTop #(
		.issueDepth(4),
		.retireDepth(2)
	) DUT (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.instr(instr),
		.resValid(resValid),
		.resReady(resReady),
		.resReg(resReg),
		.resData(resData),
		.resStatus(resStatus)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ready about five cycles in eight while throttling
	always @(posedge clk) begin
		if (throttle) begin
			pressSeed <= lcgStep(pressSeed);
			resReady <= (pressSeed[23:21] > 3'd2);
		end else begin
			resReady <= 1'b1;
		end
	end

	// =======================================================================
	// checks
	// =======================================================================

	// a stalled result stays put until taken
	property resultHeld;
		@(posedge clk) disable iff (!arstN)
		resValid && !resReady |=> resValid && $stable({resReg, resData, resStatus});
	endproperty

	holdCheck: assert property (resultHeld) else begin
		errors++;
		$display("FAILED %0t: result changed or dropped while stalled", $time);
	end

	knownCheck: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown({resValid, instrReady})) else begin
		errors++;
		$display("FAILED %0t: handshake output unknown", $time);
	end

	// compare first, then log the accepted instruction
	always @(posedge clk) begin
		if (arstN && resValid && resReady) begin
			checked++;
			if (resStatus == corePkg::statusOverflow) begin
				ovfSeen++;
			end
			if (resStatus == corePkg::statusReserved) begin
				rsvSeen++;
			end
			assert (expQ.size() != 0) else begin
				errors++;
				$display("extra result for r%0d arrived with nothing outstanding", resReg);
			end
			if (expQ.size() != 0) begin
				expPkt = expQ.pop_front();
				assert (resReg == expPkt.dest && resData == expPkt.data
					&& resStatus == expPkt.status) else begin
					errors++;
					$display("FAILED %0t: got r%0d=%h status %0d, expected r%0d=%h status %0d",
						$time, resReg, resData, resStatus, expPkt.dest, expPkt.data,
						expPkt.status);
				end
			end
		end
		if (arstN && instrValid && instrReady) begin
			applyModel(instr);
		end
	end

	// =======================================================================
	// stimulus
	// =======================================================================

	// hold valid and payload until accepted
	task automatic sendInstr(input corePkg::word w);
		instrValid <= 1'b1;
		instr <= w;
		@(posedge clk);
		while (!instrReady) begin
			@(posedge clk);
		end
		instrValid <= 1'b0;
		sent++;
	endtask

	task automatic drainAndReport(input string name, input int errs0, input int chk0);
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		assert (!resValid) else begin
			errors++;
			$display("result still valid after all expected results arrived");
		end
		$display("test %s: %0d results checked, %0d errors", name, checked - chk0,
			errors - errs0);
	endtask

	initial begin
		int e0;
		int c0;
		int o0;
		int r0;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		@(posedge clk);

		// idle outputs right after reset
		e0 = errors;
		c0 = checked;
		assert (!resValid && instrReady) else begin
			errors++;
			$display("FAILED %0t: resValid or instrReady wrong after reset", $time);
		end
		drainAndReport("reset", e0, c0);

		// load r16..r31, then independent ops into r1..r15
		e0 = errors;
		c0 = checked;
		for (int r = 16; r < 32; r++) begin
			sendInstr(encI(corePkg::opLui, r, 0, 16'(nextRand() >> 8)));
			sendInstr(encI(corePkg::opOri, r, r, 16'(nextRand() >> 16)));
		end
		for (int i = 0; i < nRandom; i++) begin
			sendInstr(randomOp(1, 15, 16, 31));
		end
		drainAndReport("random", e0, c0);

		// tight register set, r0 included
		e0 = errors;
		c0 = checked;
		for (int i = 0; i < nChain - 2; i++) begin
			sendInstr(randomOp(0, 3, 0, 3));
		end
		sendInstr(encI(corePkg::opAddiu, 0, 5, 16'h1234));
		sendInstr(encR(corePkg::fnAddu, 4, 0, 0, 0));
		drainAndReport("chain", e0, c0);

		// three overflows, two reserved, r9 reads back r8 after each
		e0 = errors;
		c0 = checked;
		o0 = ovfSeen;
		r0 = rsvSeen;
		sendInstr(encI(corePkg::opLui, 6, 0, 16'h7fff));
		sendInstr(encI(corePkg::opOri, 6, 6, 16'hffff));
		sendInstr(encI(corePkg::opAddiu, 7, 0, 16'h0001));
		sendInstr(encI(corePkg::opAddiu, 8, 0, 16'h0055));
		sendInstr(encR(corePkg::fnAdd, 8, 6, 7, 0));
		sendInstr(encR(corePkg::fnAddu, 9, 8, 0, 0));
		sendInstr(encI(corePkg::opAddi, 8, 6, 16'h0001));
		sendInstr(encI(corePkg::opLui, 10, 0, 16'h8000));
		sendInstr(encR(corePkg::fnSub, 8, 10, 7, 0));
		sendInstr(encR(corePkg::fnAddu, 9, 8, 0, 0));
		sendInstr({6'h3f, 5'd0, 5'd8, 16'h1234});
		sendInstr(encR(corePkg::fnAddu, 9, 8, 0, 0));
		sendInstr(encR(6'h01, 8, 6, 7, 0));
		sendInstr(encR(corePkg::fnAddu, 9, 8, 0, 0));
		drainAndReport("exceptions", e0, c0);
		assert (ovfSeen - o0 == 3 && rsvSeen - r0 == 2) else begin
			errors++;
			$display("FAILED %0t: saw %0d overflow and %0d reserved results", $time,
				ovfSeen - o0, rsvSeen - r0);
		end

		// random result stalls over dependent ops
		e0 = errors;
		c0 = checked;
		throttle <= 1'b1;
		for (int i = 0; i < nPressure; i++) begin
			sendInstr(randomOp(1, 12, 1, 12));
		end
		drainAndReport("pressure", e0, c0);
		throttle <= 1'b0;

		$display("results checked %0d, instructions sent %0d, errors %0d", checked, sent,
			errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (limitCycles) @(posedge clk);
		$display("run timed out after %0d cycles with %0d results outstanding",
			limitCycles, expQ.size());
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
